/* Makefile */
# Verilator build and run of the global buffer testbench

SRCS := $(filter-out +%,$(shell cat global_buffer.f))

.PHONY: run clean

run: obj_dir/Vglb_tb
	./obj_dir/Vglb_tb | tee sim.log
	grep -q "TESTS PASSED" sim.log

obj_dir/Vglb_tb: global_buffer.f $(SRCS)
	verilator --binary --timing --assert --top-module glb_tb -f global_buffer.f -o Vglb_tb

clean:
	rm -rf obj_dir sim.log

/* global_buffer.f */
rtl/global_buffer_pkg.sv
rtl/glb_bank_memory.sv
rtl/glb_bank_ctrl.sv
rtl/glb_bank_sram_cfg.sv
rtl/glb_bank.sv
rtl/glb_bank_array.sv
testbench/glb_assertions.sv
testbench/glb_checker.sv
testbench/glb_tb.sv

/* rtl/glb_bank.sv */
// glb bank
// one bank: byte strobe expansion, config adapter, controller and memory

`timescale 1ns/1ps

module glb_bank (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            clk_en,

    input  global_buffer_pkg::wr_packet_t   wr_packet,
    input  global_buffer_pkg::rdrq_packet_t rdrq_packet,
    output global_buffer_pkg::rdrs_packet_t rdrs_packet,

    input  global_buffer_pkg::cfg_req_t     cfg_req,
    output global_buffer_pkg::cfg_rsp_t     cfg_rsp
);

    localparam int AddrW = global_buffer_pkg::BANK_ADDR_WIDTH;
    localparam int DataW = global_buffer_pkg::BANK_DATA_WIDTH;
    localparam int IdxW  = AddrW - global_buffer_pkg::BANK_BYTE_OFFSET;

    logic             mem_rd_en;
    logic             mem_wr_en;
    logic [IdxW-1:0]  mem_addr;
    logic [DataW-1:0] mem_data_in;
    logic [DataW-1:0] mem_data_in_bit_sel;
    logic [DataW-1:0] mem_data_out;
    logic [DataW-1:0] wr_data_bit_sel;   // byte strobe widened to bits

    logic             cfg_wr_en;
    logic             cfg_rd_en;
    logic [AddrW-1:0] cfg_addr;
    logic [DataW-1:0] cfg_data;
    logic [DataW-1:0] cfg_bit_sel;
    logic [DataW-1:0] cfg_rd_data;
    logic             cfg_rd_data_valid;

    //====================
    // byte to bit strobe
    //====================
    always_comb begin
        for (int i = 0; i < DataW/8; i++) begin
            wr_data_bit_sel[i*8 +: 8] = {8{wr_packet.wr_strb[i]}};
        end
    end

    glb_bank_memory glb_bank_memory (
        .clk             (clk),
        .arst_n          (arst_n),
        .clk_en          (clk_en),
        .ren             (mem_rd_en),
        .wen             (mem_wr_en),
        .addr            (mem_addr),
        .data_in         (mem_data_in),
        .data_in_bit_sel (mem_data_in_bit_sel),
        .data_out        (mem_data_out)
    );

    glb_bank_ctrl glb_bank_ctrl (
        .clk                    (clk),
        .arst_n                 (arst_n),
        .clk_en                 (clk_en),
        .packet_wr_en           (wr_packet.wr_en),
        .packet_wr_addr         (wr_packet.wr_addr[AddrW-1:0]),  // bank select stripped
        .packet_wr_data         (wr_packet.wr_data),
        .packet_wr_data_bit_sel (wr_data_bit_sel),
        .packet_rd_en           (rdrq_packet.rd_en),
        .packet_rd_addr         (rdrq_packet.rd_addr[AddrW-1:0]),
        .packet_rd_data         (rdrs_packet.rd_data),
        .packet_rd_data_valid   (rdrs_packet.rd_data_valid),
        .cfg_wr_en              (cfg_wr_en),
        .cfg_rd_en              (cfg_rd_en),
        .cfg_addr               (cfg_addr),
        .cfg_data               (cfg_data),
        .cfg_bit_sel            (cfg_bit_sel),
        .cfg_rd_data            (cfg_rd_data),
        .cfg_rd_data_valid      (cfg_rd_data_valid),
        .mem_rd_en              (mem_rd_en),
        .mem_wr_en              (mem_wr_en),
        .mem_addr               (mem_addr),
        .mem_data_in            (mem_data_in),
        .mem_data_in_bit_sel    (mem_data_in_bit_sel),
        .mem_data_out           (mem_data_out)
    );

    glb_bank_sram_cfg glb_bank_sram_cfg (
        .clk                (clk),
        .arst_n             (arst_n),
        .cfg_req            (cfg_req),
        .cfg_rsp            (cfg_rsp),
        .bank_wr_en         (cfg_wr_en),
        .bank_rd_en         (cfg_rd_en),
        .bank_addr          (cfg_addr),
        .bank_data          (cfg_data),
        .bank_bit_sel       (cfg_bit_sel),
        .bank_rd_data       (cfg_rd_data),
        .bank_rd_data_valid (cfg_rd_data_valid)
    );

endmodule

/* rtl/glb_bank_array.sv */
// glb bank array, top level
// routes each request to the bank named by its upper address bits
// and or-merges the per-bank responses

`timescale 1ns/1ps

module glb_bank_array (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            clk_en,   // low gates all accesses

    input  global_buffer_pkg::wr_packet_t   wr_packet,
    input  global_buffer_pkg::rdrq_packet_t rdrq_packet,
    output global_buffer_pkg::rdrs_packet_t rdrs_packet,

    input  global_buffer_pkg::cfg_req_t     cfg_req,
    output global_buffer_pkg::cfg_rsp_t     cfg_rsp
);

    localparam int NumBanks = global_buffer_pkg::NUM_BANKS;
    localparam int SelW     = global_buffer_pkg::BANK_SEL_WIDTH;
    localparam int SelMsb   = global_buffer_pkg::GLB_ADDR_WIDTH - 1;

    global_buffer_pkg::wr_packet_t   bank_wr   [NumBanks];
    global_buffer_pkg::rdrq_packet_t bank_rdrq [NumBanks];
    global_buffer_pkg::rdrs_packet_t bank_rdrs [NumBanks];
    global_buffer_pkg::cfg_req_t     bank_cfg  [NumBanks];
    global_buffer_pkg::cfg_rsp_t     bank_cfg_rsp [NumBanks];

    //====================
    // bank select decode
    //====================
    always_comb begin
        for (int b = 0; b < NumBanks; b++) begin
            bank_wr[b]         = wr_packet;  // payload broadcast, enable qualified
            bank_wr[b].wr_en   = wr_packet.wr_en
                               && (wr_packet.wr_addr[SelMsb -: SelW] == SelW'(b));
            bank_rdrq[b]       = rdrq_packet;
            bank_rdrq[b].rd_en = rdrq_packet.rd_en
                               && (rdrq_packet.rd_addr[SelMsb -: SelW] == SelW'(b));
            bank_cfg[b]        = cfg_req;
            bank_cfg[b].wr_en  = cfg_req.wr_en && (cfg_req.addr[SelMsb -: SelW] == SelW'(b));
            bank_cfg[b].rd_en  = cfg_req.rd_en && (cfg_req.addr[SelMsb -: SelW] == SelW'(b));
        end
    end

    for (genvar g = 0; g < NumBanks; g++) begin : g_bank
        glb_bank glb_bank (
            .clk         (clk),
            .arst_n      (arst_n),
            .clk_en      (clk_en),
            .wr_packet   (bank_wr[g]),
            .rdrq_packet (bank_rdrq[g]),
            .rdrs_packet (bank_rdrs[g]),
            .cfg_req     (bank_cfg[g]),
            .cfg_rsp     (bank_cfg_rsp[g])
        );
    end

    //====================
    // response merge
    //====================
    // idle banks drive all zeros, at most one is valid per cycle
    always_comb begin
        rdrs_packet = '0;
        cfg_rsp     = '0;
        for (int b = 0; b < NumBanks; b++) begin
            rdrs_packet = rdrs_packet | bank_rdrs[b];
            cfg_rsp     = cfg_rsp | bank_cfg_rsp[b];
        end
    end

endmodule

/* rtl/glb_bank_ctrl.sv */
// glb bank controller
// fixed priority arbiter: packet write, then packet read, then config
// losing requests are dropped, two-stage read response pipeline

`timescale 1ns/1ps

module glb_bank_ctrl (
    input  logic clk,
    input  logic arst_n,
    input  logic clk_en,

    input  logic                                          packet_wr_en,
    input  logic [global_buffer_pkg::BANK_ADDR_WIDTH-1:0] packet_wr_addr,
    input  logic [global_buffer_pkg::BANK_DATA_WIDTH-1:0] packet_wr_data,
    input  logic [global_buffer_pkg::BANK_DATA_WIDTH-1:0] packet_wr_data_bit_sel,

    input  logic                                          packet_rd_en,
    input  logic [global_buffer_pkg::BANK_ADDR_WIDTH-1:0] packet_rd_addr,
    output logic [global_buffer_pkg::BANK_DATA_WIDTH-1:0] packet_rd_data,
    output logic                                          packet_rd_data_valid,

    input  logic                                          cfg_wr_en,
    input  logic                                          cfg_rd_en,
    input  logic [global_buffer_pkg::BANK_ADDR_WIDTH-1:0] cfg_addr,
    input  logic [global_buffer_pkg::BANK_DATA_WIDTH-1:0] cfg_data,
    input  logic [global_buffer_pkg::BANK_DATA_WIDTH-1:0] cfg_bit_sel,
    output logic [global_buffer_pkg::BANK_DATA_WIDTH-1:0] cfg_rd_data,
    output logic                                          cfg_rd_data_valid,

    output logic mem_rd_en,
    output logic mem_wr_en,
    output logic [global_buffer_pkg::BANK_ADDR_WIDTH-global_buffer_pkg::BANK_BYTE_OFFSET-1:0] mem_addr,
    output logic [global_buffer_pkg::BANK_DATA_WIDTH-1:0] mem_data_in,
    output logic [global_buffer_pkg::BANK_DATA_WIDTH-1:0] mem_data_in_bit_sel,
    input  logic [global_buffer_pkg::BANK_DATA_WIDTH-1:0] mem_data_out
);

    logic                                          pkt_busy;     // any packet request
    logic                                          pkt_rd_gnt;
    logic                                          cfg_wr_gnt;
    logic                                          cfg_rd_gnt;
    logic [global_buffer_pkg::BANK_ADDR_WIDTH-1:0] sel_addr;     // granted byte address
    logic                                          pkt_rd_d1;    // stage one tags
    logic                                          cfg_rd_d1;

    //====================
    // arbitration
    //====================
    assign pkt_busy   = packet_wr_en | packet_rd_en;
    assign pkt_rd_gnt = clk_en & packet_rd_en & ~packet_wr_en;   // write wins
    assign cfg_wr_gnt = clk_en & cfg_wr_en & ~pkt_busy;
    assign cfg_rd_gnt = clk_en & cfg_rd_en & ~cfg_wr_en & ~pkt_busy;

    assign mem_wr_en = (clk_en & packet_wr_en) | cfg_wr_gnt;
    assign mem_rd_en = pkt_rd_gnt | cfg_rd_gnt;

    always_comb begin
        if (packet_wr_en) begin
            sel_addr = packet_wr_addr;
        end else if (packet_rd_en) begin
            sel_addr = packet_rd_addr;
        end else begin
            sel_addr = cfg_addr;
        end
    end

    assign mem_addr            = sel_addr[global_buffer_pkg::BANK_ADDR_WIDTH-1:
                                          global_buffer_pkg::BANK_BYTE_OFFSET];  // word index
    assign mem_data_in         = packet_wr_en ? packet_wr_data : cfg_data;
    assign mem_data_in_bit_sel = packet_wr_en ? packet_wr_data_bit_sel : cfg_bit_sel;

    //====================
    // response pipeline
    //====================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pkt_rd_d1            <= 1'b0;
            cfg_rd_d1            <= 1'b0;
            packet_rd_data_valid <= 1'b0;
            packet_rd_data       <= '0;
            cfg_rd_data_valid    <= 1'b0;
            cfg_rd_data          <= '0;
        end else begin
            pkt_rd_d1            <= pkt_rd_gnt;  // memory busy this cycle
            cfg_rd_d1            <= cfg_rd_gnt;
            packet_rd_data_valid <= pkt_rd_d1;   // drains even with clk_en low
            packet_rd_data       <= pkt_rd_d1 ? mem_data_out : '0;  // zero for or-merge
            cfg_rd_data_valid    <= cfg_rd_d1;
            cfg_rd_data          <= cfg_rd_d1 ? mem_data_out : '0;
        end
    end

endmodule

/* rtl/glb_bank_memory.sv */
// glb bank memory
// behavioural single-port word array with a per-bit write mask
// read data is registered, one cycle after ren

`timescale 1ns/1ps

module glb_bank_memory (
    input  logic clk,
    input  logic arst_n,
    input  logic clk_en,

    input  logic ren,
    input  logic wen,
    input  logic [global_buffer_pkg::BANK_ADDR_WIDTH-global_buffer_pkg::BANK_BYTE_OFFSET-1:0] addr,
    input  logic [global_buffer_pkg::BANK_DATA_WIDTH-1:0] data_in,
    input  logic [global_buffer_pkg::BANK_DATA_WIDTH-1:0] data_in_bit_sel,
    output logic [global_buffer_pkg::BANK_DATA_WIDTH-1:0] data_out
);

    localparam int WordIdxWidth = global_buffer_pkg::BANK_ADDR_WIDTH
                                - global_buffer_pkg::BANK_BYTE_OFFSET;
    localparam int Depth        = 1 << WordIdxWidth;  // 512 words

    logic [global_buffer_pkg::BANK_DATA_WIDTH-1:0] mem [Depth];

    //====================
    // write port
    //====================
    always_ff @(posedge clk) begin
        if (clk_en && wen) begin
            mem[addr] <= (mem[addr] & ~data_in_bit_sel)  // keep unmasked bits
                       | (data_in & data_in_bit_sel);    // merge new bits
        end
    end

    //====================
    // read port
    //====================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            data_out <= '0;
        end else if (clk_en && ren) begin
            data_out <= mem[addr];  // holds until next read
        end
    end

endmodule

/* rtl/glb_bank_sram_cfg.sv */
// glb bank config access
// maps 32-bit half-word config requests onto 64-bit masked bank accesses
// and picks the addressed half out of the returned word

`timescale 1ns/1ps

module glb_bank_sram_cfg (
    input  logic                                          clk,
    input  logic                                          arst_n,

    input  global_buffer_pkg::cfg_req_t                   cfg_req,
    output global_buffer_pkg::cfg_rsp_t                   cfg_rsp,

    output logic                                          bank_wr_en,
    output logic                                          bank_rd_en,
    output logic [global_buffer_pkg::BANK_ADDR_WIDTH-1:0] bank_addr,
    output logic [global_buffer_pkg::BANK_DATA_WIDTH-1:0] bank_data,
    output logic [global_buffer_pkg::BANK_DATA_WIDTH-1:0] bank_bit_sel,
    input  logic [global_buffer_pkg::BANK_DATA_WIDTH-1:0] bank_rd_data,
    input  logic                                          bank_rd_data_valid
);

    localparam int HalfW = global_buffer_pkg::CFG_DATA_WIDTH;

    logic hi_sel;     // request targets upper half
    logic hi_sel_d1;  // half select delay line, matches ctrl latency
    logic hi_sel_d2;

    //====================
    // request side
    //====================
    assign hi_sel     = cfg_req.addr[2];
    assign bank_wr_en = cfg_req.wr_en;
    assign bank_rd_en = cfg_req.rd_en;
    assign bank_addr  = cfg_req.addr[global_buffer_pkg::BANK_ADDR_WIDTH-1:0];
    assign bank_data  = {2{cfg_req.wr_data}};  // same word in both halves, mask picks one

    always_comb begin
        bank_bit_sel = '0;
        if (hi_sel) begin
            bank_bit_sel[HalfW +: HalfW] = '1;
        end else begin
            bank_bit_sel[0 +: HalfW] = '1;
        end
    end

    //====================
    // response side
    //====================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hi_sel_d1 <= 1'b0;
            hi_sel_d2 <= 1'b0;
        end else begin
            hi_sel_d1 <= hi_sel;     // shifts every cycle
            hi_sel_d2 <= hi_sel_d1;  // lines up with the response valid
        end
    end

    assign cfg_rsp.rd_data       = hi_sel_d2 ? bank_rd_data[HalfW +: HalfW]
                                             : bank_rd_data[0 +: HalfW];
    assign cfg_rsp.rd_data_valid = bank_rd_data_valid;

endmodule

/* rtl/global_buffer_pkg.sv */
// global buffer shared definitions
// sizes of the banked buffer and the packet and config port structs

package global_buffer_pkg;

    //====================
    // sizes
    //====================
    localparam int NUM_BANKS        = 4;   // banks in the array
    localparam int BANK_SEL_WIDTH   = 2;   // upper address bits picking a bank
    localparam int BANK_ADDR_WIDTH  = 12;  // byte address inside a bank
    localparam int GLB_ADDR_WIDTH   = BANK_SEL_WIDTH + BANK_ADDR_WIDTH;
    localparam int BANK_DATA_WIDTH  = 64;  // one bank word
    localparam int BANK_BYTE_OFFSET = 3;   // byte bits under a word index
    localparam int CFG_DATA_WIDTH   = 32;  // config side port word

    //====================
    // packet port
    //====================
    typedef struct packed {
        logic                         wr_en;
        logic [GLB_ADDR_WIDTH-1:0]    wr_addr;  // byte address
        logic [BANK_DATA_WIDTH/8-1:0] wr_strb;  // one bit per byte lane
        logic [BANK_DATA_WIDTH-1:0]   wr_data;
    } wr_packet_t;

    typedef struct packed {
        logic                      rd_en;
        logic [GLB_ADDR_WIDTH-1:0] rd_addr;
    } rdrq_packet_t;

    typedef struct packed {
        logic [BANK_DATA_WIDTH-1:0] rd_data;
        logic                       rd_data_valid;  // single cycle pulse
    } rdrs_packet_t;

    //====================
    // config port
    //====================
    typedef struct packed {
        logic                      wr_en;
        logic                      rd_en;
        logic [GLB_ADDR_WIDTH-1:0] addr;     // bit 2 picks the upper half-word
        logic [CFG_DATA_WIDTH-1:0] wr_data;
    } cfg_req_t;

    typedef struct packed {
        logic [CFG_DATA_WIDTH-1:0] rd_data;
        logic                      rd_data_valid;
    } cfg_rsp_t;

endpackage

/* testbench/glb_assertions.sv */
// glb response timing assertions
// bound onto the bank array top level

`timescale 1ns/1ps

module glb_assertions (
    input logic                            clk,
    input logic                            arst_n,
    input logic                            clk_en,
    input global_buffer_pkg::wr_packet_t   wr_packet,
    input global_buffer_pkg::rdrq_packet_t rdrq_packet,
    input global_buffer_pkg::rdrs_packet_t rdrs_packet,
    input global_buffer_pkg::cfg_rsp_t     cfg_rsp
);

    logic rd_accepted;  // read not beaten by a write to its bank

    assign rd_accepted = clk_en && rdrq_packet.rd_en
                       && !(wr_packet.wr_en
                            && (wr_packet.wr_addr[13:12] == rdrq_packet.rd_addr[13:12]));

    a_rd_valid_after_two: assert property (@(posedge clk) disable iff (!arst_n)
        rd_accepted |-> ##2 rdrs_packet.rd_data_valid)
        else $error("read response missing two cycles after an accepted read");

    a_no_stray_valid: assert property (@(posedge clk) disable iff (!arst_n)
        rdrs_packet.rd_data_valid |-> $past(rd_accepted, 2))
        else $error("read response valid without an accepted read two cycles earlier");

    a_quiet_in_reset: assert property (@(posedge clk)
        !arst_n |-> (!rdrs_packet.rd_data_valid && !cfg_rsp.rd_data_valid))
        else $error("response valid high during reset");

endmodule

bind glb_bank_array glb_assertions i_assertions (
    .clk         (clk),
    .arst_n      (arst_n),
    .clk_en      (clk_en),
    .wr_packet   (wr_packet),
    .rdrq_packet (rdrq_packet),
    .rdrs_packet (rdrs_packet),
    .cfg_rsp     (cfg_rsp)
);

/* testbench/glb_checker.sv */
// glb response checker
// queues expected read data and matches each response valid against it

`timescale 1ns/1ps

module glb_checker (
    input  logic                            clk,
    input  logic                            arst_n,
    input  global_buffer_pkg::rdrs_packet_t rdrs_packet,
    input  global_buffer_pkg::cfg_rsp_t     cfg_rsp,
    input  logic                            exp_pkt_push,  // read accepted this edge
    input  logic [63:0]                     exp_pkt_data,
    input  logic                            exp_cfg_push,
    input  logic [31:0]                     exp_cfg_data,
    output int                              error_count,
    output int                              pending        // reads still outstanding
);

    logic [63:0] pkt_data_q [$];
    int          pkt_due_q  [$];   // cycle the valid must show up
    logic [31:0] cfg_data_q [$];
    int          cfg_due_q  [$];
    int          cyc;

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cyc         = 0;
            error_count = 0;
            pending     = 0;
        end else begin
            //====================
            // packet responses
            //====================
            if (rdrs_packet.rd_data_valid) begin
                if (pkt_due_q.size() == 0) begin
                    $display("packet read response with no read outstanding, cycle %0d", cyc);
                    error_count++;
                end else if (pkt_due_q[0] != cyc) begin
                    $display("packet read response at cycle %0d, due at cycle %0d",
                             cyc, pkt_due_q[0]);
                    error_count++;
                end else if (rdrs_packet.rd_data !== pkt_data_q[0]) begin
                    $display("[FAIL] rd_data got %h expected %h",
                             rdrs_packet.rd_data, pkt_data_q[0]);
                    error_count++;
                end
                if (pkt_due_q.size() != 0) begin
                    void'(pkt_due_q.pop_front());
                    void'(pkt_data_q.pop_front());
                end
            end
            if (pkt_due_q.size() != 0 && pkt_due_q[0] < cyc) begin
                $display("packet read response did not arrive within 2 cycles, cycle %0d", cyc);
                error_count++;
                void'(pkt_due_q.pop_front());
                void'(pkt_data_q.pop_front());
            end
            //====================
            // config responses
            //====================
            if (cfg_rsp.rd_data_valid) begin
                if (cfg_due_q.size() == 0) begin
                    $display("config read response with no read outstanding, cycle %0d", cyc);
                    error_count++;
                end else if (cfg_due_q[0] != cyc) begin
                    $display("config read response at cycle %0d, due at cycle %0d",
                             cyc, cfg_due_q[0]);
                    error_count++;
                end else if (cfg_rsp.rd_data !== cfg_data_q[0]) begin
                    $display("[FAIL] cfg rd_data got %h expected %h",
                             cfg_rsp.rd_data, cfg_data_q[0]);
                    error_count++;
                end
                if (cfg_due_q.size() != 0) begin
                    void'(cfg_due_q.pop_front());
                    void'(cfg_data_q.pop_front());
                end
            end
            if (cfg_due_q.size() != 0 && cfg_due_q[0] < cyc) begin
                $display("config read response did not arrive within 2 cycles, cycle %0d", cyc);
                error_count++;
                void'(cfg_due_q.pop_front());
                void'(cfg_data_q.pop_front());
            end
            if (exp_pkt_push) begin
                pkt_data_q.push_back(exp_pkt_data);
                pkt_due_q.push_back(cyc + 2);  // memory plus output register
            end
            if (exp_cfg_push) begin
                cfg_data_q.push_back(exp_cfg_data);
                cfg_due_q.push_back(cyc + 2);
            end
            pending = pkt_due_q.size() + cfg_due_q.size();
            cyc     = cyc + 1;
        end
    end

endmodule

/* testbench/glb_tb.sv */
// glb bank array testbench
// random packet and config traffic against a shadow memory model

`timescale 1ns/1ps

module glb_tb;

    localparam int DRAIN        = 6;                          // idle cycles after a test
    localparam int STIM_CYCLES  = 64 + 48 + 48 + 24 + 24 + 32 + 6 * DRAIN;
    localparam int TIMEOUT      = 16 + STIM_CYCLES + 100;

    logic                            clk;
    logic                            arst_n;
    logic                            clk_en;
    global_buffer_pkg::wr_packet_t   wr_packet;
    global_buffer_pkg::rdrq_packet_t rdrq_packet;
    global_buffer_pkg::rdrs_packet_t rdrs_packet;
    global_buffer_pkg::cfg_req_t     cfg_req;
    global_buffer_pkg::cfg_rsp_t     cfg_rsp;

    logic        exp_pkt_push;
    logic [63:0] exp_pkt_data;
    logic        exp_cfg_push;
    logic [31:0] exp_cfg_data;
    int          check_errors;
    int          check_pending;

    logic [63:0] shadow [2048];   // whole buffer, word indexed
    logic [13:0] written [$];     // byte addresses holding known data
    logic [31:0] seed = 32'h351e;
    logic        ref_pkt_hit;
    logic [63:0] ref_pkt_data;
    logic        ref_cfg_hit;
    logic [31:0] ref_cfg_data;
    int          test_num;
    int          start_errors;
    int          failed_tests;

    glb_bank_array i_dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .clk_en      (clk_en),
        .wr_packet   (wr_packet),
        .rdrq_packet (rdrq_packet),
        .rdrs_packet (rdrs_packet),
        .cfg_req     (cfg_req),
        .cfg_rsp     (cfg_rsp)
    );

    glb_checker i_checker (
        .clk          (clk),
        .arst_n       (arst_n),
        .rdrs_packet  (rdrs_packet),
        .cfg_rsp      (cfg_rsp),
        .exp_pkt_push (exp_pkt_push),
        .exp_pkt_data (exp_pkt_data),
        .exp_cfg_push (exp_cfg_push),
        .exp_cfg_data (exp_cfg_data),
        .error_count  (check_errors),
        .pending      (check_pending)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    //====================
    // helpers
    //====================
    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [13:0] pick_written();
        return written[lcg_next() % written.size()];
    endfunction

    function automatic global_buffer_pkg::wr_packet_t make_wr(
        input logic [13:0] addr, input logic [63:0] data, input logic [7:0] strb);
        global_buffer_pkg::wr_packet_t w;
        w.wr_en   = 1'b1;
        w.wr_addr = addr;
        w.wr_strb = strb;
        w.wr_data = data;
        return w;
    endfunction

    function automatic global_buffer_pkg::rdrq_packet_t make_rd(input logic [13:0] addr);
        global_buffer_pkg::rdrq_packet_t r;
        r.rd_en   = 1'b1;
        r.rd_addr = addr;
        return r;
    endfunction

    function automatic global_buffer_pkg::cfg_req_t make_cfg(
        input logic wr, input logic rd, input logic [13:0] addr, input logic [31:0] data);
        global_buffer_pkg::cfg_req_t c;
        c.wr_en   = wr;
        c.rd_en   = rd;
        c.addr    = addr;
        c.wr_data = data;
        return c;
    endfunction

    //====================
    // reference model
    //====================
    // reads see the word before this cycle's writes
    function automatic void ref_access(input global_buffer_pkg::wr_packet_t w,
        input global_buffer_pkg::rdrq_packet_t r, input global_buffer_pkg::cfg_req_t c,
        input logic en);
        logic        cfg_free;
        logic [63:0] word;
        ref_pkt_hit = 1'b0;
        ref_cfg_hit = 1'b0;
        if (en) begin
            ref_pkt_hit = r.rd_en && !(w.wr_en && w.wr_addr[13:12] == r.rd_addr[13:12]);
            cfg_free = !(w.wr_en && w.wr_addr[13:12] == c.addr[13:12])
                     && !(r.rd_en && r.rd_addr[13:12] == c.addr[13:12]);  // any packet wins
            ref_cfg_hit  = c.rd_en && !c.wr_en && cfg_free;
            ref_pkt_data = shadow[r.rd_addr[13:3]];
            word         = shadow[c.addr[13:3]];
            ref_cfg_data = c.addr[2] ? word[63:32] : word[31:0];
            if (w.wr_en) begin
                for (int i = 0; i < 8; i++) begin
                    if (w.wr_strb[i]) begin
                        shadow[w.wr_addr[13:3]][i*8 +: 8] = w.wr_data[i*8 +: 8];
                    end
                end
            end
            if (c.wr_en && cfg_free) begin
                if (c.addr[2]) begin
                    shadow[c.addr[13:3]][63:32] = c.wr_data;
                end else begin
                    shadow[c.addr[13:3]][31:0] = c.wr_data;
                end
            end
        end
    endfunction

    task automatic apply_cycle(input global_buffer_pkg::wr_packet_t w,
        input global_buffer_pkg::rdrq_packet_t r, input global_buffer_pkg::cfg_req_t c,
        input logic en);
        @(posedge clk);
        ref_access(w, r, c, en);
        wr_packet    <= w;
        rdrq_packet  <= r;
        cfg_req      <= c;
        clk_en       <= en;
        exp_pkt_push <= ref_pkt_hit;
        exp_pkt_data <= ref_pkt_data;
        exp_cfg_push <= ref_cfg_hit;
        exp_cfg_data <= ref_cfg_data;
    endtask

    task automatic finish_test(input string name);
        int errs;
        repeat (DRAIN) apply_cycle('0, '0, '0, 1'b1);
        errs = check_errors - start_errors;
        test_num++;
        if (errs == 0) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            $display("test %0d %s: %0d errors", test_num, name, errs);
            failed_tests++;
        end
        start_errors = check_errors;
    endtask

    //====================
    // stimulus
    //====================
    initial begin
        logic [13:0] a;
        logic [13:0] ca;
        arst_n       = 1'b0;
        clk_en       = 1'b0;
        wr_packet    = '0;
        rdrq_packet  = '0;
        cfg_req      = '0;
        exp_pkt_push = 1'b0;
        exp_pkt_data = '0;
        exp_cfg_push = 1'b0;
        exp_cfg_data = '0;
        test_num     = 0;
        start_errors = 0;
        failed_tests = 0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;

        for (int b = 0; b < 4; b++) begin   // full words, all banks
            for (int k = 0; k < 8; k++) begin
                a = 14'(b * 4096 + k * 8);
                written.push_back(a);
                apply_cycle(make_wr(a, {lcg_next(), lcg_next()}, 8'hff), '0, '0, 1'b1);
            end
        end
        foreach (written[i]) apply_cycle('0, make_rd(written[i]), '0, 1'b1);
        finish_test("full strobe writes and reads");

        for (int i = 0; i < 24; i++) begin
            a = pick_written();
            apply_cycle(make_wr(a, {lcg_next(), lcg_next()}, 8'(lcg_next())), '0, '0, 1'b1);
            apply_cycle('0, make_rd(a), '0, 1'b1);
        end
        finish_test("partial byte strobes");

        for (int i = 0; i < 16; i++) begin
            a  = pick_written();
            ca = a | ((i % 2 == 1) ? 14'h4 : 14'h0);  // alternate halves
            apply_cycle('0, '0, make_cfg(1'b1, 1'b0, ca, lcg_next()), 1'b1);
            apply_cycle('0, make_rd(a), '0, 1'b1);
            apply_cycle('0, '0, make_cfg(1'b0, 1'b1, ca, '0), 1'b1);
        end
        finish_test("config half-word access");

        for (int i = 0; i < 8; i++) begin
            a = pick_written();
            apply_cycle(make_wr(a, {lcg_next(), lcg_next()}, 8'hff), make_rd(a ^ 14'h8),
                        make_cfg(1'b1, 1'b0, a ^ 14'h10, lcg_next()), 1'b1);
            apply_cycle('0, make_rd(a), make_cfg(1'b0, 1'b1, a ^ 14'h8, '0), 1'b1);
            apply_cycle('0, make_rd(a ^ 14'h10),  // word the dropped config write aimed at
                        make_cfg(1'b0, 1'b1, a + 14'h1000, '0), 1'b1);
        end
        finish_test("same bank collisions");

        for (int i = 0; i < 8; i++) begin
            a = pick_written();
            apply_cycle('0, make_rd(a), '0, 1'b1);  // in flight over the gated cycle
            apply_cycle(make_wr(a, {lcg_next(), lcg_next()}, 8'hff), make_rd(a + 14'h2000),
                        make_cfg(1'b0, 1'b1, a + 14'h1000, '0), 1'b0);  // three banks
            apply_cycle('0, make_rd(a), '0, 1'b1);
        end
        finish_test("clock enable low");

        for (int i = 0; i < 32; i++) begin
            apply_cycle('0, make_rd(pick_written()), '0, 1'b1);
        end
        finish_test("back to back reads");

        $display("tests run %0d, tests failed %0d, check errors %0d, reads outstanding %0d",
                 test_num, failed_tests, check_errors, check_pending);
        if (failed_tests == 0 && check_errors == 0 && check_pending == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // watchdog over reset, stimulus and margin
    initial begin
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT);
        $display("TESTS FAILED");
        $finish;
    end

endmodule
